//--- filelist.f
+incdir+.
u2_rx_pkg.sv
settings_port.sv
sample_fifo.sv
rx_chan.sv
stream_combiner.sv
u2_rx_top.sv
u2_rx_assertions.sv
tb_u2_rx.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_u2_rx
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_u2_rx.sv
`timescale 1ns/100ps
`include "u2_rx_cfg.svh"

module tb_u2_rx;

   logic                   dsp_clk;
   logic                   por_rst;
   logic                   set_req_i;
   logic [`SET_ADDR_W-1:0] set_addr_i;
   logic [`SET_DATA_W-1:0] set_data_i;
   logic                   set_ack_o;
   logic [`ADC_W-1:0]      adc_a_i;
   logic [`ADC_W-1:0]      adc_b_i;
   logic [35:0]            out_data_o;
   logic                   out_valid_o;
   logic                   out_ready_i;
   logic [1:0]             overrun_o;

   integer     seed;
   logic [1:0] ready_mode;     // 0 stalled, 1 always ready, 2 random
   int         timeouts;
   int         hdr_seen [2];   // Headers accepted per channel
   int         base;
   int         total;

   bind u2_rx_top u2_rx_assertions u2_rx_assertions_i (.*);

   u2_rx_top u2_rx_top_i (.*);

   initial dsp_clk = 1'b0;
   always #20 dsp_clk = ~dsp_clk;

   ////////////////////
   // Sink and monitor

   always @(posedge dsp_clk) begin
      case (ready_mode)
         2'd0:    out_ready_i <= 1'b0;
         2'd1:    out_ready_i <= 1'b1;
         default: out_ready_i <= (($random(seed) & 3) != 0);   // Ready three cycles in four
      endcase
   end

   always @(posedge dsp_clk) begin
      if (out_valid_o && out_ready_i && out_data_o[32])
         hdr_seen[out_data_o[24]] <= hdr_seen[out_data_o[24]] + 1;
   end

   ////////////////////
   // Host and wait tasks

   task automatic write_setting(input int addr, input int data);
      int n;
      @(posedge dsp_clk);
      set_addr_i <= `SET_ADDR_W'(addr);
      set_data_i <= data;
      set_req_i  <= 1'b1;
      for (n = 0; n < 20 && !set_ack_o; n++)
         @(posedge dsp_clk);
      if (!set_ack_o) begin
         $display("Timeout: no settings ack for address %h", addr);
         timeouts++;
      end
      set_req_i <= 1'b0;   // Release after ack
      for (n = 0; n < 20 && set_ack_o; n++)
         @(posedge dsp_clk);
      if (set_ack_o) begin
         $display("Timeout: settings ack stayed high for address %h", addr);
         timeouts++;
      end
   endtask

   task automatic wait_headers(input int ch, input int count, input int limit);
      int n;
      for (n = 0; n < limit && hdr_seen[ch] < count; n++)
         @(posedge dsp_clk);
      if (hdr_seen[ch] < count) begin
         $display("Timeout: channel %0d sent %0d headers, %0d expected", ch, hdr_seen[ch], count);
         timeouts++;
      end
   endtask

   task automatic wait_overrun(input int ch, input int limit);
      int n;
      for (n = 0; n < limit && !overrun_o[ch]; n++)
         @(posedge dsp_clk);
      if (!overrun_o[ch]) begin
         $display("Timeout: overrun of channel %0d never set while stalled", ch);
         timeouts++;
      end
   endtask

   // Stream idle long enough that no frame is pending
   task automatic wait_quiet(input int limit);
      int n;
      int idle;
      idle = 0;
      for (n = 0; n < limit && idle < 32; n++) begin
         @(posedge dsp_clk);
         idle = out_valid_o ? 0 : idle + 1;
      end
      if (idle < 32) begin
         $display("Timeout: output stream did not go idle after the channels stopped");
         timeouts++;
      end
   endtask

   ////////////////////
   // Test sequence

   initial begin
      seed        = 32'h643d523a;
      por_rst     = 1'b1;
      set_req_i   = 1'b0;
      set_addr_i  = '0;
      set_data_i  = '0;
      adc_a_i     = 14'h0a5c;   // Positive
      adc_b_i     = 14'h3123;   // Negative
      out_ready_i = 1'b1;
      ready_mode  = 2'd1;
      timeouts    = 0;
      hdr_seen[0] = 0;
      hdr_seen[1] = 0;
      repeat (4) @(posedge dsp_clk);
      por_rst <= 1'b0;

      // Channel 0 alone, decim 3, sink always ready
      write_setting(`SR_RX_CHAN0 + `SR_DECIM_OFS, 3);
      write_setting(`SR_RX_CHAN0 + `SR_CTRL_OFS, 1);
      wait_headers(0, 3, 2000);

      // Both channels under random back-pressure
      write_setting(`SR_RX_CHAN1 + `SR_DECIM_OFS, 5);
      write_setting(`SR_RX_CHAN1 + `SR_CTRL_OFS, 1);
      ready_mode <= 2'd2;
      base = hdr_seen[0];
      wait_headers(1, 3, 4000);
      wait_headers(0, base + 2, 4000);

      // Stall until overrun, hold, then stop, drain and clear
      ready_mode <= 2'd0;
      wait_overrun(0, 2000);
      repeat (40) @(posedge dsp_clk);
      write_setting(`SR_RX_CHAN0 + `SR_CTRL_OFS, 0);
      write_setting(`SR_RX_CHAN1 + `SR_CTRL_OFS, 0);
      ready_mode <= 2'd1;
      wait_quiet(4000);
      write_setting(`SR_RX_CHAN0 + `SR_CTRL_OFS, 2);
      write_setting(`SR_RX_CHAN1 + `SR_CTRL_OFS, 2);

      // Restart, sequence begins again at 0
      base = hdr_seen[0];
      write_setting(`SR_RX_CHAN0 + `SR_CTRL_OFS, 1);
      wait_headers(0, base + 2, 2000);
      repeat (4) @(posedge dsp_clk);

      total = u2_rx_top_i.u2_rx_assertions_i.fail_count + timeouts;
      $display("Summary: %0d assertion failures, %0d timeouts",
               u2_rx_top_i.u2_rx_assertions_i.fail_count, timeouts);
      if (total == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   initial begin
      #4_000_000;
      $display("Global time limit reached before the test sequence finished");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

//--- u2_rx_assertions.sv
`timescale 1ns/100ps
`include "u2_rx_cfg.svh"

module u2_rx_assertions
   import u2_rx_pkg::*;
(
   input logic                   dsp_clk,
   input logic                   por_rst,
   input logic                   set_req_i,
   input logic [`SET_ADDR_W-1:0] set_addr_i,
   input logic [`SET_DATA_W-1:0] set_data_i,
   input logic                   set_ack_o,
   input logic [`ADC_W-1:0]      adc_a_i,
   input logic [`ADC_W-1:0]      adc_b_i,
   input logic [35:0]            out_data_o,
   input logic                   out_valid_o,
   input logic                   out_ready_i,
   input logic [1:0]             overrun_o
);

   int fail_count = 0;

   logic                 req_d;
   logic                 req_d2;      // Request two samples back, where ack must follow
   logic [15:0]          decim0;      // Channel 0 rate as written by the host
   logic [15:0]          exp_seq [2];
   logic                 in_frame;
   logic                 frame_chan;
   int                   smp_cnt;
   logic                 stall_d;
   logic [35:0]          data_d;
   logic [1:0]           ovr_d;
   logic [1:0]           clr_d;
   logic [1:0]           clr_d2;
   logic                 wr;
   logic                 xfer;
   logic [1:0]           clr_req;
   stream_flags_t        flags;
   stream_flags_t        exp_flags;
   stream_word_u         word;
   logic [`SAMPLE_W-1:0] sext_a;
   logic [`SAMPLE_W-1:0] sext_b;
   logic [`SAMPLE_W-1:0] exp_i;
   logic [`SAMPLE_W-1:0] exp_q;

   ////////////////////
   // Port-level model

   assign wr         = set_req_i && !req_d;   // First cycle of a host request
   assign clr_req[0] = wr && set_data_i[`CTRL_CLEAR] &&
                       (set_addr_i == `SET_ADDR_W'(`SR_RX_CHAN0 + `SR_CTRL_OFS));
   assign clr_req[1] = wr && set_data_i[`CTRL_CLEAR] &&
                       (set_addr_i == `SET_ADDR_W'(`SR_RX_CHAN1 + `SR_CTRL_OFS));
   assign xfer       = out_valid_o && out_ready_i;
   assign flags      = out_data_o[35:32];
   assign word       = out_data_o[31:0];
   assign exp_flags  = (smp_cnt == `FRAME_LEN-1) ? 4'b0010 : 4'b0000;

   // Boxcar over decim+1 equal inputs, mod 2^16
   assign sext_a = {{(`SAMPLE_W-`ADC_W){adc_a_i[`ADC_W-1]}}, adc_a_i};
   assign sext_b = {{(`SAMPLE_W-`ADC_W){adc_b_i[`ADC_W-1]}}, adc_b_i};
   assign exp_i  = sext_a * (decim0 + 16'd1);
   assign exp_q  = sext_b * (decim0 + 16'd1);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         req_d      <= 1'b0;
         req_d2     <= 1'b0;
         decim0     <= '0;
         exp_seq[0] <= '0;
         exp_seq[1] <= '0;
         in_frame   <= 1'b0;
         frame_chan <= 1'b0;
         smp_cnt    <= 0;
         stall_d    <= 1'b0;
         ovr_d      <= '0;
         clr_d      <= '0;
         clr_d2     <= '0;
      end else begin
         req_d   <= set_req_i;
         req_d2  <= req_d;
         stall_d <= out_valid_o && !out_ready_i;
         ovr_d   <= overrun_o;
         clr_d   <= clr_req;
         clr_d2  <= clr_d;
         if (wr && set_addr_i == `SET_ADDR_W'(`SR_RX_CHAN0 + `SR_DECIM_OFS))
            decim0 <= set_data_i[15:0];
         if (xfer && flags[0]) begin
            in_frame   <= 1'b1;
            frame_chan <= word.hdr.chan[0];
            smp_cnt    <= 0;
            exp_seq[word.hdr.chan[0]] <= exp_seq[word.hdr.chan[0]] + 16'd1;
         end else if (xfer && in_frame) begin
            smp_cnt <= smp_cnt + 1;
            if (smp_cnt == `FRAME_LEN-1)
               in_frame <= 1'b0;   // End of frame
         end
         if (clr_req[0])
            exp_seq[0] <= '0;
         if (clr_req[1])
            exp_seq[1] <= '0;
      end
      data_d <= out_data_o;
   end

   ////////////////////
   // Checks

   a_reset: assert property (@(posedge dsp_clk)
      por_rst |=> !set_ack_o && !out_valid_o && overrun_o == 2'b00)
      else begin
         fail_count++;
         $error("CHECK FAILED reset set_ack_o %h out_valid_o %h overrun_o %h expected 0",
                set_ack_o, out_valid_o, overrun_o);
      end

   a_ack: assert property (@(posedge dsp_clk) disable iff (por_rst) set_ack_o == req_d2)
      else begin
         fail_count++;
         $error("CHECK FAILED set_ack_o %h expected %h", set_ack_o, req_d2);
      end

   a_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      stall_d |-> out_valid_o && out_data_o == data_d)
      else begin
         fail_count++;
         $error("CHECK FAILED out_data_o %h expected %h while stalled, out_valid_o %h",
                out_data_o, data_d, out_valid_o);
      end

   // Header fields, with the sequence count per channel
   a_hdr: assert property (@(posedge dsp_clk) disable iff (por_rst)
      xfer && !in_frame |-> flags == 4'b0001 && word.hdr.chan < 8'd2 &&
                            word.hdr.len == 8'(`FRAME_LEN) &&
                            word.hdr.seq == exp_seq[word.hdr.chan[0]])
      else begin
         fail_count++;
         $error("CHECK FAILED out_data_o header %h expected seq %h",
                out_data_o, exp_seq[word.hdr.chan[0]]);
      end

   a_smp_flags: assert property (@(posedge dsp_clk) disable iff (por_rst)
      xfer && in_frame |-> flags == exp_flags)
      else begin
         fail_count++;
         $error("CHECK FAILED out_data_o flags %h expected %h", flags, exp_flags);
      end

   a_smp_val: assert property (@(posedge dsp_clk) disable iff (por_rst)
      xfer && in_frame && !frame_chan |-> word.smp.i == exp_i && word.smp.q == exp_q)
      else begin
         fail_count++;
         $error("CHECK FAILED out_data_o sample %h expected %h", word, {exp_i, exp_q});
      end

   // Overrun falls only two cycles after a clear request
   a_sticky: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (ovr_d & ~overrun_o & ~clr_d2) == 2'b00)
      else begin
         fail_count++;
         $error("CHECK FAILED overrun_o %h previous %h", overrun_o, ovr_d);
      end

   a_clear: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (clr_d2 & overrun_o) == 2'b00)
      else begin
         fail_count++;
         $error("CHECK FAILED overrun_o %h after clear of %h", overrun_o, clr_d2);
      end

endmodule

//--- u2_rx_top.sv
`timescale 1ns/100ps
`include "u2_rx_cfg.svh"

module u2_rx_top
   import u2_rx_pkg::*;
(
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   set_req_i,
   input  logic [`SET_ADDR_W-1:0] set_addr_i,
   input  logic [`SET_DATA_W-1:0] set_data_i,
   output logic                   set_ack_o,
   input  logic [`ADC_W-1:0]      adc_a_i,
   input  logic [`ADC_W-1:0]      adc_b_i,
   output logic [35:0]            out_data_o,
   output logic                   out_valid_o,
   input  logic                   out_ready_i,
   output logic [1:0]             overrun_o
);

   logic                             set_stb;
   logic [`SET_ADDR_W-1:0]           set_addr;
   logic [`SET_DATA_W-1:0]           set_data;
   stream_word_u                     head0;
   stream_word_u                     head1;
   logic [$clog2(`FIFO_DEPTH+1)-1:0] level0;
   logic [$clog2(`FIFO_DEPTH+1)-1:0] level1;
   logic                             pop0;
   logic                             pop1;
   logic [1:0]                       clear;

   // Clear writes, seen by the combiner on the same edge as the channels
   assign clear[0] = set_stb && set_data[`CTRL_CLEAR] &&
                     (set_addr == `SET_ADDR_W'(`SR_RX_CHAN0 + `SR_CTRL_OFS));
   assign clear[1] = set_stb && set_data[`CTRL_CLEAR] &&
                     (set_addr == `SET_ADDR_W'(`SR_RX_CHAN1 + `SR_CTRL_OFS));

   ////////////////////
   // Host settings

   settings_port settings_port_i (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_req_i  (set_req_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .set_ack_o  (set_ack_o),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   ////////////////////
   // Receive channels

   rx_chan #(.BASE(`SR_RX_CHAN0)) rx_chan0_i (
      .dsp_clk (dsp_clk), .por_rst (por_rst),
      .set_stb_i (set_stb), .set_addr_i (set_addr), .set_data_i (set_data),
      .adc_a_i (adc_a_i), .adc_b_i (adc_b_i),
      .pop_i (pop0), .head_o (head0), .level_o (level0),
      .overrun_o (overrun_o[0])
   );

   rx_chan #(.BASE(`SR_RX_CHAN1)) rx_chan1_i (
      .dsp_clk (dsp_clk), .por_rst (por_rst),
      .set_stb_i (set_stb), .set_addr_i (set_addr), .set_data_i (set_data),
      .adc_a_i (adc_a_i), .adc_b_i (adc_b_i),
      .pop_i (pop1), .head_o (head1), .level_o (level1),
      .overrun_o (overrun_o[1])
   );

   ////////////////////
   // Packet stream

   stream_combiner stream_combiner_i (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .head0_i     (head0),
      .level0_i    (level0),
      .head1_i     (head1),
      .level1_i    (level1),
      .out_ready_i (out_ready_i),
      .clear_i     (clear),
      .pop0_o      (pop0),
      .pop1_o      (pop1),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o)
   );

endmodule

//--- stream_combiner.sv
`timescale 1ns/100ps
`include "u2_rx_cfg.svh"

module stream_combiner
   import u2_rx_pkg::*;
(
   input  logic                             dsp_clk,
   input  logic                             por_rst,
   input  stream_word_u                     head0_i,
   input  logic [$clog2(`FIFO_DEPTH+1)-1:0] level0_i,
   input  stream_word_u                     head1_i,
   input  logic [$clog2(`FIFO_DEPTH+1)-1:0] level1_i,
   input  logic                             out_ready_i,
   input  logic [1:0]                       clear_i,
   output logic                             pop0_o,
   output logic                             pop1_o,
   output logic [35:0]                      out_data_o,
   output logic                             out_valid_o
);

   localparam int CNT_W = (`FRAME_LEN > 1) ? $clog2(`FRAME_LEN) : 1;

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_HDR  = 2'd1;
   localparam logic [1:0] ST_SMP  = 2'd2;

   logic [1:0]       state_q;
   logic             chan_q;     // Channel owning the current frame
   logic             rr_q;       // Channel with priority next
   logic [15:0]      seq_q [2];
   logic [CNT_W-1:0] cnt_q;      // Samples loaded so far
   logic             valid_q;
   stream_word_u     word_q;
   stream_flags_t    flags_q;

   logic [1:0]                       frm_rdy;
   logic                             pick;
   logic                             pick_vld;
   logic                             can_load;
   logic                             hdr_ld;
   logic                             smp_ld;
   logic                             last;
   logic [$clog2(`FIFO_DEPTH+1)-1:0] level_act;
   stream_word_u                     head_act;
   stream_word_u                     hdr_w;

   ////////////////////
   // Next-word selection

   always_comb begin
      frm_rdy   = {level1_i >= `FRAME_LEN, level0_i >= `FRAME_LEN};
      level_act = chan_q ? level1_i : level0_i;
      head_act  = chan_q ? head1_i : head0_i;

      // Round robin, fall back to the other channel
      pick     = rr_q;
      pick_vld = 1'b0;
      if (frm_rdy[rr_q]) begin
         pick_vld = 1'b1;
      end else if (frm_rdy[~rr_q]) begin
         pick     = ~rr_q;
         pick_vld = 1'b1;
      end

      // Output register free or draining this cycle
      can_load = !valid_q || out_ready_i;
      hdr_ld   = (state_q == ST_HDR) && can_load;
      smp_ld   = (state_q == ST_SMP) && can_load && (level_act != '0);
      last     = (cnt_q == CNT_W'(`FRAME_LEN-1));

      hdr_w          = '0;
      hdr_w.hdr.chan = {7'd0, chan_q};
      hdr_w.hdr.len  = 8'(`FRAME_LEN);
      hdr_w.hdr.seq  = seq_q[chan_q];
   end

   assign pop0_o = smp_ld && !chan_q;
   assign pop1_o = smp_ld && chan_q;

   ////////////////////
   // Frame FSM

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q <= ST_IDLE;
         chan_q  <= 1'b0;
         rr_q    <= 1'b0;
         cnt_q   <= '0;
         valid_q <= 1'b0;
      end else begin
         if (out_ready_i)
            valid_q <= 1'b0;   // Word taken, nothing new unless loaded below
         case (state_q)
            ST_IDLE: begin
               if (pick_vld) begin
                  chan_q  <= pick;
                  rr_q    <= ~pick;
                  state_q <= ST_HDR;
               end
            end
            ST_HDR: begin
               if (hdr_ld) begin
                  valid_q <= 1'b1;
                  cnt_q   <= '0;
                  state_q <= ST_SMP;
               end
            end
            ST_SMP: begin
               // Waits here if a clear emptied the buffer mid-frame
               if (smp_ld) begin
                  valid_q <= 1'b1;
                  cnt_q   <= cnt_q + 1'b1;
                  if (last)
                     state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Sequence numbers advance as each header is loaded
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         seq_q[0] <= '0;
         seq_q[1] <= '0;
      end else begin
         if (hdr_ld)
            seq_q[chan_q] <= seq_q[chan_q] + 1'b1;
         for (int c = 0; c < 2; c++) begin
            if (clear_i[c])
               seq_q[c] <= '0;
         end
      end
   end

   ////////////////////
   // Output word

   always_ff @(posedge dsp_clk) begin
      if (hdr_ld) begin
         word_q  <= hdr_w;
         flags_q <= stream_flags_t'(4'b0001);   // Start of frame
      end else if (smp_ld) begin
         word_q  <= head_act;                   // Sample passes through as is
         flags_q <= last ? stream_flags_t'(4'b0010) : stream_flags_t'(4'b0000);
      end
   end

   assign out_data_o  = {flags_q, word_q};
   assign out_valid_o = valid_q;

endmodule

//--- rx_chan.sv
`timescale 1ns/100ps
`include "u2_rx_cfg.svh"

module rx_chan
   import u2_rx_pkg::*;
#(
   parameter int BASE = `SR_RX_CHAN0
) (
   input  logic                             dsp_clk,
   input  logic                             por_rst,
   input  logic                             set_stb_i,
   input  logic [`SET_ADDR_W-1:0]           set_addr_i,
   input  logic [`SET_DATA_W-1:0]           set_data_i,
   input  logic [`ADC_W-1:0]                adc_a_i,
   input  logic [`ADC_W-1:0]                adc_b_i,
   input  logic                             pop_i,
   output stream_word_u                     head_o,
   output logic [$clog2(`FIFO_DEPTH+1)-1:0] level_o,
   output logic                             overrun_o
);

   logic [15:0]            decim_q;    // Rate minus one
   logic                   run_q;
   logic                   overrun_q;
   logic [15:0]            phase_q;    // Position in the boxcar window
   logic [`SAMPLE_W-1:0]   acc_i_q;
   logic [`SAMPLE_W-1:0]   acc_q_q;
   logic [`SAMPLE_W-1:0]   sum_i;
   logic [`SAMPLE_W-1:0]   sum_q;
   logic                   decim_wr;
   logic                   ctrl_wr;
   logic                   clear;
   logic                   done;
   logic                   fifo_full;
   logic [2*`SAMPLE_W-1:0] fifo_head;

   ////////////////////
   // Settings decode

   assign decim_wr = set_stb_i && (set_addr_i == `SET_ADDR_W'(BASE + `SR_DECIM_OFS));
   assign ctrl_wr  = set_stb_i && (set_addr_i == `SET_ADDR_W'(BASE + `SR_CTRL_OFS));
   assign clear    = ctrl_wr && set_data_i[`CTRL_CLEAR];   // One-cycle pulse

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         decim_q <= '0;
         run_q   <= 1'b0;
      end else begin
         if (decim_wr)
            decim_q <= set_data_i[15:0];
         if (ctrl_wr)
            run_q <= set_data_i[`CTRL_RUN];
      end
   end

   ////////////////////
   // Boxcar decimator

   // Sign-extended running sums, wrap mod 2^16
   assign sum_i = acc_i_q + {{(`SAMPLE_W-`ADC_W){adc_a_i[`ADC_W-1]}}, adc_a_i};
   assign sum_q = acc_q_q + {{(`SAMPLE_W-`ADC_W){adc_b_i[`ADC_W-1]}}, adc_b_i};

   // Window closes after decim+1 inputs, >= covers a rate lowered mid-window
   assign done = run_q && (phase_q >= decim_q);

   always_ff @(posedge dsp_clk) begin
      if (por_rst || !run_q || done)
         phase_q <= '0;
      else
         phase_q <= phase_q + 1'b1;
   end

   always_ff @(posedge dsp_clk) begin
      if (!run_q || done) begin
         acc_i_q <= '0;     // Next window starts empty
         acc_q_q <= '0;
      end else begin
         acc_i_q <= sum_i;
         acc_q_q <= sum_q;
      end
   end

   ////////////////////
   // Sample buffer

   sample_fifo #(
      .DEPTH(`FIFO_DEPTH)
   ) sample_fifo_i (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .clear_i     (clear),
      .push_i      (done && !fifo_full),
      .push_data_i ({sum_i, sum_q}),    // I upper, Q lower
      .pop_i       (pop_i),
      .pop_data_o  (fifo_head),
      .level_o     (level_o),
      .full_o      (fifo_full)
   );

   // Sticky until a clear write
   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear)
         overrun_q <= 1'b0;
      else if (done && fifo_full)
         overrun_q <= 1'b1;
   end

   assign head_o    = fifo_head;
   assign overrun_o = overrun_q;

endmodule

//--- sample_fifo.sv
`timescale 1ns/100ps
`include "u2_rx_cfg.svh"

module sample_fifo #(
   parameter int DEPTH = `FIFO_DEPTH
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       clear_i,
   input  logic                       push_i,
   input  logic [2*`SAMPLE_W-1:0]     push_data_i,
   input  logic                       pop_i,
   output logic [2*`SAMPLE_W-1:0]     pop_data_o,
   output logic [$clog2(DEPTH+1)-1:0] level_o,
   output logic                       full_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH+1);

   logic [2*`SAMPLE_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [CNT_W-1:0]       count;
   logic                   do_push;
   logic                   do_pop;

   // Wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH-1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full_o  = (count == CNT_W'(DEPTH));
   assign do_push = push_i & ~full_o;        // Writes to a full buffer are dropped
   assign do_pop  = pop_i & (count != '0);

   always_ff @(posedge dsp_clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_next(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   assign pop_data_o = mem[rd_ptr];   // Head word, valid while level is nonzero
   assign level_o    = count;

endmodule

//--- settings_port.sv
`timescale 1ns/100ps
`include "u2_rx_cfg.svh"

module settings_port (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   set_req_i,
   input  logic [`SET_ADDR_W-1:0] set_addr_i,
   input  logic [`SET_DATA_W-1:0] set_data_i,
   output logic                   set_ack_o,
   output logic                   set_stb_o,
   output logic [`SET_ADDR_W-1:0] set_addr_o,
   output logic [`SET_DATA_W-1:0] set_data_o
);

   logic                   req_q;    // Request as sampled last edge
   logic                   stb_q;
   logic                   ack_q;
   logic [`SET_ADDR_W-1:0] addr_q;
   logic [`SET_DATA_W-1:0] data_q;
   logic                   new_req;

   // Rising edge of the host request
   assign new_req = set_req_i & ~req_q;

   ////////////////////
   // Handshake state

   // The strobe sits between request capture and ack rise,
   // so the registers behind it update on the edge that raises ack.
   // Ack then simply trails the sampled request by one cycle
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         req_q <= 1'b0;
         stb_q <= 1'b0;
         ack_q <= 1'b0;
      end else begin
         req_q <= set_req_i;
         stb_q <= new_req;     // One pulse per handshake
         ack_q <= req_q;
      end
   end

   ////////////////////
   // Address and data capture

   // Host holds these stable while req is high
   always_ff @(posedge dsp_clk) begin
      if (new_req) begin
         addr_q <= set_addr_i;
         data_q <= set_data_i;
      end
   end

   assign set_ack_o  = ack_q;
   assign set_stb_o  = stb_q;
   assign set_addr_o = addr_q;
   assign set_data_o = data_q;

endmodule

//--- u2_rx_pkg.sv
`include "u2_rx_cfg.svh"

package u2_rx_pkg;

   // One word of the packet stream
   // Header words and sample words share the same 32 bits
   typedef union packed {
      struct packed {
         logic [7:0]  chan;   // Channel number
         logic [7:0]  len;    // Samples in this frame
         logic [15:0] seq;    // Per-channel frame count
      } hdr;
      struct packed {
         logic [`SAMPLE_W-1:0] i;
         logic [`SAMPLE_W-1:0] q;
      } smp;
   } stream_word_u;

   // Upper four bits of a stream word
   // Bit 0 start of frame, bit 1 end of frame, rest zero
   typedef logic [3:0] stream_flags_t;

endpackage

//--- u2_rx_cfg.svh
`ifndef U2_RX_CFG_SVH
`define U2_RX_CFG_SVH

////////////////////
// Settings bus

`define SET_ADDR_W 8
`define SET_DATA_W 32

////////////////////
// Sample widths

`define ADC_W 14
`define SAMPLE_W 16

////////////////////
// Channel register map

`define SR_RX_CHAN0 32
`define SR_RX_CHAN1 48

`define SR_DECIM_OFS 0    // Decimation rate minus one
`define SR_CTRL_OFS 1

// Control register bits
`define CTRL_RUN 0
`define CTRL_CLEAR 1

////////////////////
// Framing and buffering

`define FRAME_LEN 8       // Samples per packet
`define FIFO_DEPTH 16     // Samples per channel

`endif
